//--- sim/pps_stim.txt
# name  rise_ch0 rise_ch1 rise_ch2 rise_ch3 (63 = none)
# exp: locked_mask(hex) sel_valid sel_channel sel_phase pps_out_count sel_changed_count
idle        63 63 63 63  0 0 0 0   0 0
ch2_first   63 63 10 63  0 0 0 0   0 0
ch2_lock    63 63 10 63  4 1 2 13  0 1
ch2_late    63 63 11 63  4 1 2 13  1 0
ch2_early   63 63  9 63  4 1 2 13  1 0
slip_01     63 63 11 63  4 1 2 13  1 0
slip_02     63 63 11 63  4 1 2 13  1 0
slip_03     63 63 11 63  4 1 2 13  1 0
slip_04     63 63 11 63  4 1 2 13  1 0
slip_05     63 63 11 63  4 1 2 13  1 0
slip_06     63 63 11 63  4 1 2 13  1 0
slip_07     63 63 11 63  4 1 2 13  1 0
slip_08     63 63 11 63  4 1 2 13  1 0
slip_09     63 63 11 63  4 1 2 13  1 0
slip_10     63 63 11 63  4 1 2 13  1 0
slip_11     63 63 11 63  4 1 2 13  1 0
slip_12     63 63 11 63  4 1 2 13  1 0
slip_13     63 63 11 63  4 1 2 13  1 0
slip_14     63 63 11 63  4 1 2 13  1 0
slip_15     63 63 11 63  4 1 2 13  1 0
slip_16     63 63 11 63  4 1 2 14  1 0
ch2_hold    63 63 11 63  4 1 2 14  1 0
ch2_jump    63 63 30 63  0 0 0 0   1 1
ch2_relock  63 63 30 63  4 1 2 33  0 1
ch13_first  63 20 63 40  0 0 0 0   1 1
ch13_lock   63 20 63 40  a 1 1 23  0 1
ch13_steady 63 20 63 40  a 1 1 23  1 0
ch1_miss    63 63 63 40  8 1 3 43  2 1
ch3_only    63 63 63 40  8 1 3 43  1 0
all_off     63 63 63 63  0 0 0 0   1 1
silent      63 63 63 63  0 0 0 0   0 0

//--- src.f
verilog/pps_pkg.sv
verilog/pps_second_counter.sv
verilog/pps_phase_tracker.sv
verilog/pps_source_select.sv
verilog/pps_timing_top.sv
sim/pps_tb_clock.sv
sim/pps_timing_checker.sv
sim/pps_timing_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := pps_timing_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/pps_timing_tb.sv
/*
 * Testbench for the 1PPS timing front end
 *   - reads one line per simulated second from the stim file
 *   - drives pps_in pulses and checks lock, selection and pulse counts
 *   - watchdog sized from the number of stim lines
 */

module pps_timing_tb;

    import pps_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_LINES  = 64;
    localparam int PULSE_LEN  = 4;
    localparam int CHECK_TICK = 62;
    localparam int NO_PULSE   = 63;

    logic                                      clk;
    logic                                      aresetn;
    logic [NUM_CHANNELS-1:0]                   pps_in;
    logic                                      pps_out;
    logic                                      sel_valid;
    chan_t                                     sel_channel;
    phase_t                                    sel_phase;
    logic                                      sel_changed;
    logic [NUM_CHANNELS-1:0]                   ch_locked;
    logic [NUM_CHANNELS*PHASE_WIDTH-1:0]       ch_phase_all;

    string name_tab [MAX_LINES];
    int    pos_tab  [MAX_LINES][NUM_CHANNELS];
    int    exp_tab  [MAX_LINES][6];
    int    n_lines  = 0;
    int    n_fail   = 0;
    int    n_errors = 0;
    bit    stim_loaded = 1'b0;
    bit    test_bad;

    pps_tb_clock pps_tb_clock_i (
        .clk     (clk),
        .aresetn (aresetn)
    );

    pps_timing_top pps_timing_top_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .pps_in       (pps_in),
        .pps_out      (pps_out),
        .sel_valid    (sel_valid),
        .sel_channel  (sel_channel),
        .sel_phase    (sel_phase),
        .sel_changed  (sel_changed),
        .ch_locked    (ch_locked),
        .ch_phase_all (ch_phase_all)
    );

    bind pps_source_select pps_timing_checker sel_chk_i (
        .clk(clk), .aresetn(aresetn), .pps_out(pps_out), .sel_valid(sel_valid),
        .sel_changed(sel_changed), .ch_edge(1'b0)
    );

    bind pps_phase_tracker pps_timing_checker edge_chk_i (
        .clk(clk), .aresetn(aresetn), .pps_out(1'b0), .sel_valid(1'b0),
        .sel_changed(1'b0), .ch_edge(ch_edge)
    );

    // Compare tasks
    // ====================

    task automatic check_mask(string name, logic [NUM_CHANNELS-1:0] exp,
                              logic [NUM_CHANNELS-1:0] act);
        if (exp !== act) begin
            $display("** Error %s: ch_locked expected %h, actual %h", name, exp, act);
            n_errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("** Error %s: sel_valid expected %b, actual %b", name, exp, act);
            n_errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_chan(string name, chan_t exp, chan_t act);
        if (exp !== act) begin
            $display("** Error %s: sel_channel expected %0d, actual %0d", name, exp, act);
            n_errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_phase(string name, string what, phase_t exp, phase_t act);
        if (exp !== act) begin
            $display("** Error %s: %s expected %0d, actual %0d", name, what, exp, act);
            n_errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_count(string name, string what, int exp, int act);
        if (exp != act) begin
            $display("** Error %s: %s count expected %0d, actual %0d", name, what, exp, act);
            n_errors++;
            test_bad = 1'b1;
        end
    endtask

    // Stim file
    // ====================

    // Columns: name, four rise ticks, mask, valid, channel, phase, pps count, change count
    task automatic load_stim();
        int    fd;
        int    got;
        string line;
        string name;
        int    p [NUM_CHANNELS];
        int    e [6];
        fd = $fopen("sim/pps_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stim file sim/pps_stim.txt");
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 2 && line.substr(0, 0) != "#") begin
                got = $sscanf(line, "%s %d %d %d %d %h %d %d %d %d %d", name,
                              p[0], p[1], p[2], p[3], e[0], e[1], e[2], e[3], e[4], e[5]);
                if (got == 11) begin
                    name_tab[n_lines] = name;
                    pos_tab[n_lines]  = p;
                    exp_tab[n_lines]  = e;
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // One simulated second, starting with the counter at 0
    task automatic run_second(int l);
        logic [NUM_CHANNELS-1:0] vec;
        int                      n_pps;
        int                      n_chg;
        n_pps    = 0;
        n_chg    = 0;
        test_bad = 1'b0;
        for (int t = 0; t < TICKS_PER_SECOND; t++) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                vec[i] = (pos_tab[l][i] != NO_PULSE) && (t >= pos_tab[l][i]) &&
                         (t < pos_tab[l][i] + PULSE_LEN);
            end
            pps_in <= vec;
            // Values seen here were held through the previous cycle
            if (pps_out) n_pps++;
            if (sel_changed) n_chg++;
            if (t == CHECK_TICK) begin
                check_mask(name_tab[l], exp_tab[l][0][NUM_CHANNELS-1:0], ch_locked);
                check_bit(name_tab[l], exp_tab[l][1][0], sel_valid);
                check_chan(name_tab[l], chan_t'(exp_tab[l][2]), sel_channel);
                check_phase(name_tab[l], "sel_phase", phase_t'(exp_tab[l][3]), sel_phase);
                // Tracked phase of the expected channel in the observation bus
                if (exp_tab[l][1] != 0) begin
                    check_phase(name_tab[l], "ch_phase_all", phase_t'(exp_tab[l][3]),
                                ch_phase_all[exp_tab[l][2]*PHASE_WIDTH +: PHASE_WIDTH]);
                end
            end
            @(posedge clk);
        end
        check_count(name_tab[l], "pps_out", exp_tab[l][4], n_pps);
        check_count(name_tab[l], "sel_changed", exp_tab[l][5], n_chg);
        if (test_bad) begin
            n_fail++;
            $display("%s: FAILED", name_tab[l]);
        end else begin
            $display("%s: ok", name_tab[l]);
        end
    endtask

    // Main sequence
    // ====================

    initial begin
        pps_in = '0;
        load_stim();
        stim_loaded = 1'b1;
        if (n_lines == 0) begin
            $display("No usable stim lines were read");
            $display("Done: errors found");
            $finish;
        end else begin
            @(posedge aresetn);
            for (int l = 0; l < n_lines; l++) begin
                run_second(l);
            end
            $display("Tests: %0d, failed: %0d, mismatches: %0d", n_lines, n_fail, n_errors);
            if (n_errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // Watchdog
    initial begin
        wait (stim_loaded);
        #((n_lines + 2) * TICKS_PER_SECOND * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- sim/pps_timing_checker.sv
/*
 * Concurrent assertions for the 1PPS front end
 *   - pps_out pulse width and link to sel_valid
 *   - sel_changed pulse width
 *   - spacing of tracker edge strobes
 */

module pps_timing_checker (
    input logic clk,
    input logic aresetn,
    input logic pps_out,
    input logic sel_valid,
    input logic sel_changed,
    input logic ch_edge
);

    a_pps_single: assert property (@(posedge clk) disable iff (!aresetn)
        pps_out |=> !pps_out)
        else $error("pps_out high for two cycles in a row");

    // Selection still valid while the pulse is out
    a_pps_valid: assert property (@(posedge clk) disable iff (!aresetn)
        pps_out |-> sel_valid)
        else $error("pps_out without a valid selection");

    a_changed_single: assert property (@(posedge clk) disable iff (!aresetn)
        sel_changed |=> !sel_changed)
        else $error("sel_changed wider than one cycle");

    a_edge_spacing: assert property (@(posedge clk) disable iff (!aresetn)
        ch_edge |=> !ch_edge ##1 !ch_edge)
        else $error("ch_edge repeated within two cycles");

endmodule

//--- sim/pps_tb_clock.sv
/*
 * Testbench clock and reset
 *   - clk with a period of 4
 *   - aresetn held low for 10 cycles
 */

module pps_tb_clock (
    output logic clk,
    output logic aresetn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (10) @(posedge clk);
        aresetn <= 1'b1;
    end

endmodule

//--- verilog/pps_timing_top.sv
/*
 * 1PPS timing front end top level
 *   - shared second counter
 *   - one phase tracker per PPS input
 *   - source selector and pps_out regeneration
 *   - lock mask and concatenated phases for observation
 */

module pps_timing_top (
    input  logic                                               clk,
    input  logic                                               aresetn,
    input  logic [pps_pkg::NUM_CHANNELS-1:0]                   pps_in,
    output logic                                               pps_out,
    output logic                                               sel_valid,
    output pps_pkg::chan_t                                     sel_channel,
    output pps_pkg::phase_t                                    sel_phase,
    output logic                                               sel_changed,
    output logic [pps_pkg::NUM_CHANNELS-1:0]                   ch_locked,
    output logic [pps_pkg::NUM_CHANNELS*pps_pkg::PHASE_WIDTH-1:0] ch_phase_all
);

    import pps_pkg::*;

    phase_t     second_count;
    ch_status_e ch_status [NUM_CHANNELS];
    phase_t     ch_phase  [NUM_CHANNELS];

    pps_second_counter pps_second_counter_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .second_count (second_count)
    );

    // One tracker per input
    // ====================

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_track
        pps_phase_tracker pps_phase_tracker_i (
            .clk          (clk),
            .aresetn      (aresetn),
            .pps_in       (pps_in[i]),
            .second_count (second_count),
            // Edge strobe only feeds the tracker's own history
            .ch_edge      (),
            .ch_phase     (ch_phase[i]),
            .ch_status    (ch_status[i])
        );

        assign ch_locked[i]                            = (ch_status[i] == CH_LOCKED);
        assign ch_phase_all[i*PHASE_WIDTH +: PHASE_WIDTH] = ch_phase[i];
    end

    pps_source_select pps_source_select_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .second_count (second_count),
        .ch_status    (ch_status),
        .ch_phase     (ch_phase),
        .pps_out      (pps_out),
        .sel_valid    (sel_valid),
        .sel_channel  (sel_channel),
        .sel_phase    (sel_phase),
        .sel_changed  (sel_changed)
    );

endmodule

//--- verilog/pps_source_select.sv
/*
 * PPS source selector
 *   - priority pick of the lowest-numbered locked channel
 *   - registered selection with change strobe
 *   - pps_out regenerated from the shared second counter
 */

module pps_source_select (
    input  logic                clk,
    input  logic                aresetn,
    input  pps_pkg::phase_t     second_count,
    input  pps_pkg::ch_status_e ch_status [pps_pkg::NUM_CHANNELS],
    input  pps_pkg::phase_t     ch_phase  [pps_pkg::NUM_CHANNELS],
    output logic                pps_out,
    output logic                sel_valid,
    output pps_pkg::chan_t      sel_channel,
    output pps_pkg::phase_t     sel_phase,
    output logic                sel_changed
);

    import pps_pkg::*;

    logic   pick_valid;
    chan_t  pick_channel;
    phase_t pick_phase;

    // Priority encoder
    // ====================

    // Walk down so the lowest locked index wins
    always_comb begin
        pick_valid   = 1'b0;
        pick_channel = '0;
        pick_phase   = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (ch_status[i] == CH_LOCKED) begin
                pick_valid   = 1'b1;
                pick_channel = chan_t'(i);
                pick_phase   = ch_phase[i];
            end
        end
    end

    // Selection register
    // ====================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            sel_valid   <= 1'b0;
            sel_channel <= '0;
            sel_phase   <= '0;
            sel_changed <= 1'b0;
        end else begin
            sel_valid   <= pick_valid;
            sel_channel <= pick_channel;
            sel_phase   <= pick_phase;
            // Phase slips on the same channel are not a change
            sel_changed <= (pick_valid != sel_valid) || (pick_channel != sel_channel);
        end
    end

    // Output pulse
    // ====================

    // One cycle after the counter passes the selected phase
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pps_out <= 1'b0;
        end else begin
            pps_out <= sel_valid && (second_count == sel_phase);
        end
    end

endmodule

//--- verilog/pps_phase_tracker.sv
/*
 * Per-input PPS phase tracker
 *   - two-flop synchronizer and registered rising edge strobe
 *   - phase relation of each edge against the tracked phase
 *   - slip hysteresis with separate early and late counters
 *   - lock status with missed pulse detection
 */

module pps_phase_tracker (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                pps_in,
    input  pps_pkg::phase_t     second_count,
    output logic                ch_edge,
    output pps_pkg::phase_t     ch_phase,
    output pps_pkg::ch_status_e ch_status
);

    import pps_pkg::*;

    localparam logic [3:0] SLIP_LAST = 4'(SLIP_LIMIT - 1);

    logic       sync_1;
    logic       sync_2;
    logic       sync_d;
    logic [2:0] edge_hist;
    logic [3:0] early_cnt;
    logic [3:0] late_cnt;
    phase_t     phase_early;
    phase_t     phase_late;
    phase_t     phase_miss;
    phase_rel_e rel;

    // Phase arithmetic modulo one second
    function automatic phase_t phase_add(phase_t p, int unsigned n);
        return phase_t'((p + n) % TICKS_PER_SECOND);
    endfunction

    // Synchronizer and edge detect
    // ====================

    // Edge strobe lands 3 cycles after pps_in is first sampled high
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            sync_1  <= 1'b0;
            sync_2  <= 1'b0;
            sync_d  <= 1'b0;
            ch_edge <= 1'b0;
        end else begin
            sync_1  <= pps_in;
            sync_2  <= sync_1;
            sync_d  <= sync_2;
            ch_edge <= sync_2 & ~sync_d;
        end
    end

    // Edges seen in the last three cycles, newest in bit 0
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            edge_hist <= '0;
        end else begin
            edge_hist <= {edge_hist[1:0], ch_edge};
        end
    end

    // Phase classification
    // ====================

    assign phase_early = phase_add(ch_phase, TICKS_PER_SECOND - 1);
    assign phase_late  = phase_add(ch_phase, 1);
    assign phase_miss  = phase_add(ch_phase, 2);

    always_comb begin
        if (second_count == ch_phase) begin
            rel = REL_MATCH;
        end else if (second_count == phase_early) begin
            rel = REL_EARLY;
        end else if (second_count == phase_late) begin
            rel = REL_LATE;
        end else begin
            rel = REL_JUMP;
        end
    end

    // Phase and status update
    // ====================

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ch_phase  <= '0;
            early_cnt <= '0;
            late_cnt  <= '0;
            ch_status <= CH_LOST;
        end else if (ch_edge) begin
            case (rel)
                REL_MATCH: begin
                    early_cnt <= '0;
                    late_cnt  <= '0;
                    ch_status <= CH_LOCKED;
                end
                REL_EARLY: begin
                    late_cnt  <= '0;
                    ch_status <= CH_LOCKED;
                    if (early_cnt == SLIP_LAST) begin
                        ch_phase  <= second_count;
                        early_cnt <= '0;
                    end else begin
                        early_cnt <= early_cnt + 4'd1;
                    end
                end
                REL_LATE: begin
                    early_cnt <= '0;
                    ch_status <= CH_LOCKED;
                    if (late_cnt == SLIP_LAST) begin
                        ch_phase <= second_count;
                        late_cnt <= '0;
                    end else begin
                        late_cnt <= late_cnt + 4'd1;
                    end
                end
                default: begin
                    // Large jump, take the new phase straight away
                    ch_phase  <= second_count;
                    early_cnt <= '0;
                    late_cnt  <= '0;
                    ch_status <= CH_LOST;
                end
            endcase
        end else if (second_count == phase_miss && edge_hist == 3'b000) begin
            // Window p-1 .. p+1 has passed without an edge
            ch_status <= CH_LOST;
        end
    end

endmodule

//--- verilog/pps_second_counter.sv
/*
 * Free-running second counter
 *   - wraps from TICKS_PER_SECOND-1 to 0
 *   - common time base for all PPS inputs
 */

module pps_second_counter (
    input  logic            clk,
    input  logic            aresetn,
    output pps_pkg::phase_t second_count
);

    import pps_pkg::*;

    localparam phase_t LAST_TICK = phase_t'(TICKS_PER_SECOND - 1);

    // Held at 0 through reset, so the first cycle after release reads 0
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            second_count <= '0;
        end else if (second_count == LAST_TICK) begin
            second_count <= '0;
        end else begin
            second_count <= second_count + phase_t'(1);
        end
    end

endmodule

//--- verilog/pps_pkg.sv
/*
 * Shared definitions for the 1PPS timing front end
 *   - timing constants (ticks per second, channel count, slip limit)
 *   - derived widths for phase and channel index values
 *   - phase and channel index types
 *   - channel status enum and tracker phase relation enum
 */

package pps_pkg;

    // Timing constants
    // ====================

    // Stand-in for the real clock frequency
    localparam int TICKS_PER_SECOND = 64;
    localparam int NUM_CHANNELS     = 4;

    // Consecutive one-tick deviations before a slip is adopted
    localparam int SLIP_LIMIT       = 16;

    localparam int PHASE_WIDTH      = $clog2(TICKS_PER_SECOND);
    localparam int CHAN_WIDTH       = $clog2(NUM_CHANNELS);

    // Types
    // ====================

    typedef logic [PHASE_WIDTH-1:0] phase_t;
    typedef logic [CHAN_WIDTH-1:0]  chan_t;

    typedef enum logic {
        CH_LOST   = 1'b0,
        CH_LOCKED = 1'b1
    } ch_status_e;

    // Measured edge against tracked phase
    typedef enum logic [1:0] {
        REL_MATCH = 2'd0,
        REL_EARLY = 2'd1,
        REL_LATE  = 2'd2,
        REL_JUMP  = 2'd3
    } phase_rel_e;

endpackage
